// File: hw/morse_pkg.sv
package morse_pkg;

    // ====================================================================
    // key packets
    // ====================================================================
    typedef enum logic [7:0] {
        KEY_NONE = 8'd0,
        KEY_DOT  = 8'd1,
        KEY_DASH = 8'd2
    } key_code_t;

    localparam logic [2:0] PKT_TYPE_KEY = 3'd1;

    typedef struct packed {
        logic [2:0] pkt_type;  // always PKT_TYPE_KEY here
        key_code_t  code;
    } key_packet_t;

    // ====================================================================
    // LCD pins and cursor
    // ====================================================================
    typedef struct packed {
        logic       e;
        logic       rs;   // 0 command, 1 data
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    typedef struct packed {
        logic       row;
        logic [3:0] col;
    } lcd_cursor_t;

    // HD44780 commands, 8-bit interface
    localparam logic [7:0] CMD_WAKEUP     = 8'h30;
    localparam logic [7:0] CMD_FUNC_SET   = 8'h38;  // 8-bit, 2 lines, 5x8
    localparam logic [7:0] CMD_DISP_OFF   = 8'h08;
    localparam logic [7:0] CMD_DISP_CLEAR = 8'h01;
    localparam logic [7:0] CMD_ENTRY_MODE = 8'h06;  // increment, no shift
    localparam logic [7:0] CMD_DISP_ON    = 8'h0C;  // cursor off
    localparam logic [7:0] CMD_SET_DDRAM  = 8'h80;

    localparam logic [7:0] CHAR_DOT  = 8'h2E;
    localparam logic [7:0] CHAR_DASH = 8'h2D;

    // ====================================================================
    // timing
    // ====================================================================
    typedef logic [31:0] cnt_t;

    // e pulse window, counted from the start of a step
    localparam cnt_t E_PULSE_START = 32'd2;
    localparam cnt_t E_PULSE_END   = 32'd22;

    function automatic cnt_t cycles_us(input longint unsigned clk_hz,
                                       input longint unsigned us);
        return cnt_t'((clk_hz * us) / 64'd1_000_000);
    endfunction

endpackage

// File: hw/key_frontend.sv
`timescale 1ns/1ps

module key_frontend #(
    parameter int DEBOUNCE_CYCLES = 250_000,
    parameter int QUEUE_DEPTH     = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   btn_dot,
    input  logic                   btn_dash,
    input  logic                   credit_return,
    output logic                   key_valid,
    output morse_pkg::key_packet_t key_packet,
    output logic                   key_dropped
);
    import morse_pkg::*;

    localparam int DW       = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int CW       = $clog2(QUEUE_DEPTH + 1);
    localparam int BTN_DOT  = 0;
    localparam int BTN_DASH = 1;

    logic [1:0]    btn_raw;
    logic [1:0]    sync_q0, sync_q1;
    logic [1:0]    stable, prev, press;
    logic [DW-1:0] db_cnt [2];
    logic [CW-1:0] credits;
    logic          any_press, send, drop;

    assign btn_raw[BTN_DOT]  = btn_dot;
    assign btn_raw[BTN_DASH] = btn_dash;

    // ====================================================================
    // sync, debounce, rising edge (both buttons)
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q0 <= '0;
            sync_q1 <= '0;
        end else begin
            sync_q0 <= btn_raw;
            sync_q1 <= sync_q0;
        end
    end

    // level must hold past DEBOUNCE_CYCLES before it is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable <= '0;
            db_cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sync_q1[i] != stable[i]) begin
                    if (db_cnt[i] >= DW'(DEBOUNCE_CYCLES)) begin
                        stable[i] <= sync_q1[i];
                        db_cnt[i] <= '0;
                    end else begin
                        db_cnt[i] <= db_cnt[i] + 1'b1;
                    end
                end else begin
                    db_cnt[i] <= '0;  // bounce, start over
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev  <= '0;
            press <= '0;
        end else begin
            prev  <= stable;
            press <= stable & ~prev;  // one pulse per press
        end
    end

    // ====================================================================
    // encoder and credit counter
    // ====================================================================
    assign any_press = |press;
    assign send      = any_press && (credits != '0);
    assign drop      = any_press && (credits == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_valid   <= 1'b0;
            key_dropped <= 1'b0;
            credits     <= CW'(QUEUE_DEPTH);
        end else begin
            key_valid   <= send;
            key_dropped <= drop;
            credits     <= credits - CW'(send) + CW'(credit_return);
        end
    end

    // dot wins a tie, the dash of that cycle is lost
    always_ff @(posedge clk) begin
        if (send) begin
            key_packet.pkt_type <= PKT_TYPE_KEY;
            key_packet.code     <= press[BTN_DOT] ? KEY_DOT : KEY_DASH;
        end
    end

endmodule

// File: hw/key_queue.sv
`timescale 1ns/1ps

module key_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   key_valid,
    input  morse_pkg::key_packet_t key_packet,
    input  logic                   pop,
    output logic                   head_valid,
    output morse_pkg::key_packet_t head,
    output logic                   credit_return
);
    import morse_pkg::*;

    localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    key_packet_t   mem [QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    // pointers wrap at the depth, not at a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    // no full check, the sender never holds more credits than slots
    always_ff @(posedge clk) begin
        if (key_valid) begin
            mem[wr_ptr] <= key_packet;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (key_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            count         <= count + CW'(key_valid) - CW'(do_pop);
            credit_return <= do_pop;  // slot freed, give the credit back
        end
    end

endmodule

// File: hw/lcd_timer.sv
`timescale 1ns/1ps

module lcd_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            step_start,
    input  morse_pkg::cnt_t step_len,
    input  logic            pulse_en,
    output logic            e_out,
    output logic            step_done
);
    import morse_pkg::*;

    cnt_t cnt, cnt_next, len_q;
    logic running, run_next;
    logic en_q, en_next;

    // cnt reads n in the n-th cycle after step_start
    assign step_done = running && (cnt == len_q + 32'd1);
    assign run_next  = step_start || (running && !step_done);
    assign en_next   = step_start ? pulse_en : en_q;
    assign cnt_next  = step_start ? 32'd1 : (run_next ? cnt + 32'd1 : cnt);

    always_ff @(posedge clk) begin
        if (step_start) len_q <= step_len;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            running <= 1'b0;
            en_q    <= 1'b0;
            e_out   <= 1'b0;
        end else begin
            cnt     <= cnt_next;
            running <= run_next;
            en_q    <= en_next;
            // registered so the pin is clean, window in step cycles
            e_out   <= run_next && en_next &&
                       (cnt_next >= E_PULSE_START) && (cnt_next < E_PULSE_END);
        end
    end

endmodule

// File: hw/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter int CLK_HZ = 25_000_000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   head_valid,
    input  morse_pkg::key_packet_t head,
    input  logic                   e_in,
    input  logic                   step_done,
    output logic                   pop,
    output logic                   step_start,
    output morse_pkg::cnt_t        step_len,
    output logic                   pulse_en,
    output morse_pkg::lcd_bus_t    lcd,
    output logic                   lcd_ready
);
    import morse_pkg::*;

    // step lengths, e window included where there is a pulse
    localparam cnt_t LEN_PWR   = cycles_us(CLK_HZ, 15_000);
    localparam cnt_t LEN_WAKE1 = E_PULSE_END + cycles_us(CLK_HZ, 5_000);
    localparam cnt_t LEN_WAKE2 = E_PULSE_END + cycles_us(CLK_HZ, 100);
    localparam cnt_t LEN_CLEAR = E_PULSE_END + cycles_us(CLK_HZ, 2_000);
    localparam cnt_t LEN_CMD   = E_PULSE_END + cycles_us(CLK_HZ, 50);

    typedef enum logic [3:0] {
        ST_PWR_WAIT,
        ST_WAKE_1,
        ST_WAKE_2,
        ST_WAKE_3,
        ST_FUNC_SET,
        ST_DISP_OFF,
        ST_DISP_CLR,
        ST_ENTRY_MODE,
        ST_DISP_ON,
        ST_IDLE,
        ST_SET_ADDR,
        ST_WRITE_CHAR
    } state_t;

    state_t      state;
    lcd_cursor_t cursor;
    logic        issue;
    logic [7:0]  char_q;
    logic [7:0]  data_sel;
    logic        rs_sel;

    assign step_start = issue;
    assign pop        = (state == ST_IDLE) && head_valid;

    // ====================================================================
    // per step command, rs and length
    // ====================================================================
    always_comb begin
        data_sel = CMD_WAKEUP;
        rs_sel   = 1'b0;
        step_len = LEN_CMD;
        pulse_en = 1'b1;
        case (state)
            ST_PWR_WAIT: begin
                step_len = LEN_PWR;
                pulse_en = 1'b0;  // just wait
            end
            ST_WAKE_1:     step_len = LEN_WAKE1;
            ST_WAKE_2:     step_len = LEN_WAKE2;
            ST_WAKE_3:     step_len = LEN_CMD;
            ST_FUNC_SET:   data_sel = CMD_FUNC_SET;
            ST_DISP_OFF:   data_sel = CMD_DISP_OFF;
            ST_DISP_CLR: begin
                data_sel = CMD_DISP_CLEAR;
                step_len = LEN_CLEAR;
            end
            ST_ENTRY_MODE: data_sel = CMD_ENTRY_MODE;
            ST_DISP_ON:    data_sel = CMD_DISP_ON;
            ST_SET_ADDR:   data_sel = CMD_SET_DDRAM | {1'b0, cursor.row, 2'b00, cursor.col};
            ST_WRITE_CHAR: begin
                data_sel = char_q;
                rs_sel   = 1'b1;
            end
            default: begin  // idle, nothing to send
                step_len = '0;
                pulse_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        lcd.e    = e_in;
        lcd.rs   = rs_sel;
        lcd.rw   = 1'b0;  // write only
        lcd.data = data_sel;
    end

    // ====================================================================
    // state machine
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_PWR_WAIT;
            issue     <= 1'b1;  // power wait starts out of reset
            lcd_ready <= 1'b0;
            cursor    <= '0;
        end else begin
            issue <= 1'b0;
            if (state == ST_IDLE) begin
                if (head_valid) begin
                    state <= ST_SET_ADDR;
                    issue <= 1'b1;
                end
            end else if (step_done) begin
                issue <= 1'b1;
                case (state)
                    ST_PWR_WAIT:   state <= ST_WAKE_1;
                    ST_WAKE_1:     state <= ST_WAKE_2;
                    ST_WAKE_2:     state <= ST_WAKE_3;
                    ST_WAKE_3:     state <= ST_FUNC_SET;
                    ST_FUNC_SET:   state <= ST_DISP_OFF;
                    ST_DISP_OFF:   state <= ST_DISP_CLR;
                    ST_DISP_CLR:   state <= ST_ENTRY_MODE;
                    ST_ENTRY_MODE: state <= ST_DISP_ON;
                    ST_DISP_ON: begin
                        state     <= ST_IDLE;
                        issue     <= 1'b0;
                        lcd_ready <= 1'b1;  // stays up from here on
                    end
                    ST_SET_ADDR:   state <= ST_WRITE_CHAR;
                    ST_WRITE_CHAR: begin
                        state      <= ST_IDLE;
                        issue      <= 1'b0;
                        cursor.col <= cursor.col + 4'd1;
                        if (cursor.col == 4'd15) cursor.row <= ~cursor.row;
                    end
                    default: state <= ST_PWR_WAIT;
                endcase
            end
        end
    end

    // character for the key being written
    always_ff @(posedge clk) begin
        if (pop) char_q <= (head.code == KEY_DASH) ? CHAR_DASH : CHAR_DOT;
    end

endmodule

// File: hw/morse_lcd_top.sv
`timescale 1ns/1ps

module morse_lcd_top #(
    parameter int CLK_HZ          = 25_000_000,
    parameter int DEBOUNCE_CYCLES = 250_000,   // 10 ms at 25 MHz
    parameter int QUEUE_DEPTH     = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                btn_dot,
    input  logic                btn_dash,
    output morse_pkg::lcd_bus_t lcd,
    output logic                lcd_ready,
    output logic                key_dropped
);
    import morse_pkg::*;

    // ====================================================================
    // key path
    // ====================================================================
    logic        key_valid, credit_return;
    key_packet_t key_packet;
    logic        head_valid, pop;
    key_packet_t head;

    key_frontend #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) key_frontend_i (
        .clk, .rst_n, .btn_dot, .btn_dash, .credit_return,
        .key_valid, .key_packet, .key_dropped
    );

    key_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) key_queue_i (
        .clk, .rst_n, .key_valid, .key_packet, .pop,
        .head_valid, .head, .credit_return
    );

    // ====================================================================
    // LCD path
    // ====================================================================
    logic step_start, step_done, pulse_en, e_out;
    cnt_t step_len;

    lcd_timer lcd_timer_i (
        .clk, .rst_n, .step_start, .step_len, .pulse_en,
        .e_out, .step_done
    );

    lcd_sequencer #(
        .CLK_HZ (CLK_HZ)
    ) lcd_sequencer_i (
        .clk, .rst_n, .head_valid, .head,
        .e_in (e_out),
        .step_done, .pop, .step_start, .step_len, .pulse_en,
        .lcd, .lcd_ready
    );

endmodule

// File: bench/morse_lcd_asserts.sv
`timescale 1ns/1ps

module morse_lcd_asserts #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             key_valid,
    input logic                             key_dropped,
    input logic                             credit_return,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0] credits
);
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    int            fails = 0;  // failed assertions so far
    logic [CW-1:0] free_slots;  // credits as the port traffic shows them

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_slots <= CW'(QUEUE_DEPTH);
        end else begin
            free_slots <= free_slots - CW'(key_valid) + CW'(credit_return);
        end
    end

    // every packet needs a slot the queue has not handed out yet
    spent_credit: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> free_slots != '0)
    else begin
        $error("key_valid sent with no credit left");
        fails++;
    end

    send_or_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !(key_valid && key_dropped))
    else begin
        $error("key_valid and key_dropped high together");
        fails++;
    end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= QUEUE_DEPTH)
    else begin
        $error("credit count above queue depth");
        fails++;
    end

endmodule

bind key_frontend morse_lcd_asserts #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) key_asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .key_valid     (key_valid),
    .key_dropped   (key_dropped),
    .credit_return (credit_return),
    .credits       (credits)
);

// File: bench/morse_lcd_tb.sv
`timescale 1ns/1ps

module morse_lcd_tb;
    import morse_pkg::*;

    localparam int CLK_HZ          = 1_000_000;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int QUEUE_DEPTH     = 4;
    localparam int HOLD_CYCLES     = DEBOUNCE_CYCLES + 8;  // past sync and debounce
    localparam int KEY_LIMIT       = cycles_us(CLK_HZ, 300);
    localparam int INIT_LIMIT      = cycles_us(CLK_HZ, 25_000);
    // init twice plus 39 keys, doubled, 10 ns per cycle
    localparam longint WATCHDOG_NS = 64'd20 * (2 * cycles_us(CLK_HZ, 22_000) + 39 * KEY_LIMIT);

    logic       clk, rst_n, btn_dot, btn_dash;
    lcd_bus_t   lcd;
    logic       lcd_ready, key_dropped;
    lcd_bus_t   lcd_log[$];  // every word latched by the LCD
    int         drop_count, key_count, value_errors, other_errors;
    logic [7:0] lfsr;

    morse_lcd_top #(
        .CLK_HZ          (CLK_HZ),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) morse_lcd_top_i (
        .clk, .rst_n, .btn_dot, .btn_dash, .lcd, .lcd_ready, .key_dropped
    );

    always #5 clk = ~clk;

    // LCD takes the bus on the falling edge of e
    always @(negedge lcd.e) begin
        if (rst_n === 1'b1) lcd_log.push_back(lcd);
    end

    always @(negedge clk) begin
        if (rst_n && key_dropped) drop_count++;
    end

    // ====================================================================
    // helpers
    // ====================================================================
    function automatic logic [7:0] next_lfsr(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);  // galois, taps 8,6,5,4
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = next_lfsr(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    task automatic random_key(output key_code_t k);
        int b;
        take_bits(1, b);
        k = b ? KEY_DASH : KEY_DOT;
    endtask

    // row 0 at 00, row 1 at 40, 32 cells then wrap
    function automatic logic [7:0] ddram_addr(input int n);
        int pos;
        pos = n % 32;
        return 8'h80 | ((pos >= 16) ? 8'h40 : 8'h00) | 8'(pos % 16);
    endfunction

    function automatic key_code_t char_key(input logic [7:0] c);
        if (c == 8'h2E) return KEY_DOT;
        if (c == 8'h2D) return KEY_DASH;
        return KEY_NONE;
    endfunction

    task automatic check_lcd_word(input string name, input lcd_bus_t got, input lcd_bus_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got rs=%b rw=%b data=%h, expected rs=%b rw=%b data=%h",
                     $time, name, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
            value_errors++;
        end
    endtask

    task automatic check_key_code(input string name, input key_code_t got, input key_code_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_words(input int n, input int limit);
        int waited;
        waited = 0;
        while (lcd_log.size() < n && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (lcd_log.size() < n) begin
            $display("timeout at %0t: only %0d of %0d LCD words arrived", $time,
                     lcd_log.size(), n);
            other_errors++;
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!lcd_ready && waited < INIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!lcd_ready) begin
            $display("timeout at %0t: lcd_ready never rose", $time);
            other_errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic press_key(input logic dot, input logic dash);
        @(negedge clk);
        btn_dot  = dot;
        btn_dash = dash;
        repeat (HOLD_CYCLES) @(negedge clk);
        btn_dot  = 1'b0;
        btn_dash = 1'b0;
    endtask

    task automatic random_gap();
        int extra;
        take_bits(5, extra);
        repeat (HOLD_CYCLES + 4 + extra) @(negedge clk);  // release settles first
    endtask

    // address word then data word for the next cursor cell
    task automatic check_key(input int base, input key_code_t k);
        lcd_bus_t addr;
        if (lcd_log.size() < base + 2) return;
        addr = '{e: 1'b0, rs: 1'b0, rw: 1'b0, data: ddram_addr(key_count)};
        check_lcd_word("lcd address", lcd_log[base], addr);
        check_flag("lcd.rs", lcd_log[base + 1].rs, 1'b1);
        check_key_code("lcd char", char_key(lcd_log[base + 1].data), k);
        key_count++;
    endtask

    task automatic echo_key(input key_code_t k);
        int base;
        base = lcd_log.size();
        press_key(k == KEY_DOT, k == KEY_DASH);
        wait_words(base + 2, KEY_LIMIT);
        check_key(base, k);
        random_gap();
    endtask

    // ====================================================================
    // directed tests
    // ====================================================================
    task automatic test_init();
        logic [7:0] codes [8] = '{8'h30, 8'h30, 8'h30, 8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};
        wait_words(8, INIT_LIMIT);
        check_flag("lcd_ready", lcd_ready, 1'b0);  // not before the last word
        for (int i = 0; i < 8 && i < lcd_log.size(); i++) begin
            check_lcd_word("lcd init word", lcd_log[i],
                           '{e: 1'b0, rs: 1'b0, rw: 1'b0, data: codes[i]});
        end
        wait_ready();
        check_count("init words", lcd_log.size(), 8);
    endtask

    task automatic test_bounce();
        int words, drops;
        words = lcd_log.size();
        drops = drop_count;
        for (int i = 1; i < DEBOUNCE_CYCLES; i++) begin
            @(negedge clk);
            btn_dot  = i[0];
            btn_dash = !i[0];
            repeat (i) @(negedge clk);
            btn_dot  = 1'b0;
            btn_dash = 1'b0;
            repeat (DEBOUNCE_CYCLES + 4) @(negedge clk);
        end
        repeat (KEY_LIMIT) @(negedge clk);
        check_count("lcd words", lcd_log.size(), words);
        check_count("key_dropped pulses", drop_count, drops);
    endtask

    // starts at col 2, runs across row 1 and back into row 0
    task automatic test_wrap();
        key_code_t k;
        for (int i = 0; i < 32; i++) begin
            random_key(k);
            echo_key(k);
        end
    endtask

    task automatic test_backpressure();
        key_code_t sent [$];
        key_code_t k;
        int        base, drops;
        apply_reset();
        base      = lcd_log.size();
        drops     = drop_count;
        key_count = 0;
        for (int i = 0; i < 6; i++) begin
            random_key(k);
            sent.push_back(k);
            press_key(k == KEY_DOT, k == KEY_DASH);
            random_gap();
        end
        check_flag("lcd_ready", lcd_ready, 1'b0);
        wait_ready();
        check_count("key_dropped pulses", drop_count - drops, 2);
        wait_words(base + 16, 4 * KEY_LIMIT);
        for (int i = 0; i < 4; i++) begin
            check_key(base + 8 + 2 * i, sent[i]);
        end
        repeat (KEY_LIMIT) @(negedge clk);
        check_count("lcd words", lcd_log.size() - base, 16);
    endtask

    task automatic test_dot_priority();
        int base;
        base = lcd_log.size();
        press_key(1'b1, 1'b1);
        wait_words(base + 2, KEY_LIMIT);
        check_key(base, KEY_DOT);
        repeat (KEY_LIMIT) @(negedge clk);
        check_count("lcd words", lcd_log.size() - base, 2);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        btn_dot      = 1'b0;
        btn_dash     = 1'b0;
        lfsr         = 8'd21;
        drop_count   = 0;
        key_count    = 0;
        value_errors = 0;
        other_errors = 0;
        apply_reset();
        test_init();
        echo_key(KEY_DOT);
        echo_key(KEY_DASH);
        test_bounce();
        test_wrap();
        test_backpressure();
        test_dot_priority();
        $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 morse_lcd_top_i.key_frontend_i.key_asserts_i.fails);
        if (value_errors == 0 && other_errors == 0 &&
            morse_lcd_top_i.key_frontend_i.key_asserts_i.fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: files.f
hw/morse_pkg.sv
hw/key_frontend.sv
hw/key_queue.sv
hw/lcd_timer.sv
hw/lcd_sequencer.sv
hw/morse_lcd_top.sv
bench/morse_lcd_asserts.sv
bench/morse_lcd_tb.sv

// File: Bender.yml
package:
  name: morse_lcd

sources:
  - hw/morse_pkg.sv
  - hw/key_frontend.sv
  - hw/key_queue.sv
  - hw/lcd_timer.sv
  - hw/lcd_sequencer.sv
  - hw/morse_lcd_top.sv
  - target: test
    files:
      - bench/morse_lcd_asserts.sv
      - bench/morse_lcd_tb.sv
